// ==== logic/ex_pkg.sv ====
`default_nettype none

package ex_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [4:0]      shamt_t;

    // kept integer micro-ops; the result class follows from these
    typedef enum logic [5:0] {
        UOP_ADD, UOP_SUB, UOP_AND, UOP_OR, UOP_XOR,
        UOP_SLT, UOP_SLTU, UOP_SLL, UOP_SRL, UOP_SRA,
        UOP_ADDI, UOP_ANDI, UOP_ORI, UOP_XORI,
        UOP_SLTI, UOP_SLTIU, UOP_SLLI, UOP_SRLI, UOP_SRAI,
        UOP_LUI, UOP_AUIPC,
        UOP_JAL, UOP_JALR,
        UOP_BEQ, UOP_BNE, UOP_BLT, UOP_BGE, UOP_BLTU, UOP_BGEU
    } uop_t;

    // link registers seen by the return-address stack
    localparam reg_addr_t LINK_RA = 5'd1;
    localparam reg_addr_t LINK_T0 = 5'd5;

    localparam word_t INSN_BYTES = 32'd4;

    // one prepared operation, as it sits in the execute queue
    typedef struct packed {
        uop_t      uop;
        word_t     pc;
        word_t     op_a;          // rs1 data
        word_t     op_b;          // rs2 or immediate
        word_t     rs2;           // for branch compares
        word_t     target;        // pc+imm, or rs1+imm for jalr
        reg_addr_t rd_a;
        logic      rd_we;
        reg_addr_t rs1_a;
        word_t     pred_next_pc;
        logic      pred_taken;
    } ex_entry_t;

endpackage

`default_nettype wire

// ==== logic/ex_alu.sv ====
`default_nettype none

module ex_alu (
    input  ex_pkg::uop_t  uop_i,
    input  ex_pkg::word_t op_a_i,
    input  ex_pkg::word_t op_b_i,
    input  ex_pkg::word_t rs2_i,
    input  ex_pkg::word_t pc_i,
    output ex_pkg::word_t result_o,
    output logic          cond_o
);
    import ex_pkg::*;

    shamt_t shamt;
    logic   lt_signed;
    logic   lt_unsigned;
    logic   br_eq;
    logic   br_lt;
    logic   br_ltu;

    assign shamt       = op_b_i[4:0];
    assign lt_signed   = $signed(op_a_i) < $signed(op_b_i);
    assign lt_unsigned = op_a_i < op_b_i;

    // branches always compare against rs2, never the immediate
    assign br_eq  = (op_a_i == rs2_i);
    assign br_lt  = $signed(op_a_i) < $signed(rs2_i);
    assign br_ltu = op_a_i < rs2_i;

    always_comb begin
        case (uop_i)
            UOP_ADD, UOP_ADDI:  result_o = op_a_i + op_b_i;
            UOP_SUB:            result_o = op_a_i - op_b_i;
            UOP_AND, UOP_ANDI:  result_o = op_a_i & op_b_i;
            UOP_OR, UOP_ORI:    result_o = op_a_i | op_b_i;
            UOP_XOR, UOP_XORI:  result_o = op_a_i ^ op_b_i;
            UOP_SLT, UOP_SLTI:  result_o = {{(XLEN-1){1'b0}}, lt_signed};
            UOP_SLTU, UOP_SLTIU: result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
            UOP_SLL, UOP_SLLI:  result_o = op_a_i << shamt;
            UOP_SRL, UOP_SRLI:  result_o = op_a_i >> shamt;
            UOP_SRA, UOP_SRAI:  result_o = word_t'($signed(op_a_i) >>> shamt);  // sign fill
            UOP_LUI:            result_o = op_b_i;
            UOP_AUIPC, UOP_JAL, UOP_JALR: result_o = pc_i + INSN_BYTES;  // link value
            default:            result_o = '0;
        endcase
    end

    always_comb begin
        case (uop_i)
            UOP_BEQ:  cond_o = br_eq;
            UOP_BNE:  cond_o = !br_eq;
            UOP_BLT:  cond_o = br_lt;
            UOP_BGE:  cond_o = !br_lt;
            UOP_BLTU: cond_o = br_ltu;
            UOP_BGEU: cond_o = !br_ltu;
            default:  cond_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/ex_issue.sv ====
`default_nettype none

module ex_issue (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              flush_i,
    input  logic              almost_full_i,
    input  logic              valid_i,
    input  ex_pkg::uop_t      uop_i,
    input  ex_pkg::word_t     pc_i,
    input  ex_pkg::reg_addr_t rs1_a_i,
    input  ex_pkg::word_t     rs1_d_i,
    input  ex_pkg::word_t     rs2_d_i,
    input  ex_pkg::word_t     imm_i,
    input  ex_pkg::reg_addr_t rd_a_i,
    input  logic              rd_we_i,
    input  ex_pkg::word_t     next_pc_i,
    input  logic              next_taken_i,
    output logic              valid_o,
    output ex_pkg::ex_entry_t entry_o
);
    import ex_pkg::*;

    logic      use_imm;
    word_t     target;
    ex_entry_t next_entry;

    always_comb begin
        case (uop_i)
            UOP_ADDI, UOP_ANDI, UOP_ORI, UOP_XORI,
            UOP_SLTI, UOP_SLTIU, UOP_SLLI, UOP_SRLI, UOP_SRAI,
            UOP_LUI: use_imm = 1'b1;
            default: use_imm = 1'b0;
        endcase
    end

    // jalr is register relative, everything else pc relative
    assign target = (uop_i == UOP_JALR) ? rs1_d_i + imm_i : pc_i + imm_i;

    always_comb begin
        next_entry.uop          = uop_i;
        next_entry.pc           = pc_i;
        next_entry.op_a         = rs1_d_i;
        next_entry.op_b         = use_imm ? imm_i : rs2_d_i;
        next_entry.rs2          = rs2_d_i;
        next_entry.target       = target;
        next_entry.rd_a         = rd_a_i;
        next_entry.rd_we        = rd_we_i;
        next_entry.rs1_a        = rs1_a_i;
        next_entry.pred_next_pc = next_pc_i;
        next_entry.pred_taken   = next_taken_i;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            valid_o <= 1'b0;    // a flush also drops this cycle's valid_i
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            entry_o <= next_entry;
        end
    end

    // the front end must back off while the queue is nearly full
    a_no_issue_on_stall: assert property (
        @(posedge clk_i) disable iff (rst_i) valid_i |-> !almost_full_i
    );

endmodule

`default_nettype wire

// ==== logic/ex_queue.sv ====
`default_nettype none

module ex_queue #(
    parameter int DEPTH = 4
) (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              flush_i,
    input  logic              push_i,
    input  ex_pkg::ex_entry_t push_entry_i,
    input  logic              pop_i,
    output logic              head_valid_o,
    output ex_pkg::ex_entry_t head_entry_o,
    output logic              almost_full_o
);
    import ex_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    ex_entry_t        mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;

    // wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full          = (count == CNT_W'(DEPTH));
    assign head_valid_o  = (count != '0);
    assign head_entry_o  = mem_q[rd_ptr];
    assign almost_full_o = (count >= CNT_W'(DEPTH - 1));  // one slot kept for issue reg

    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop_i) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i && !flush_i) begin
            mem_q[wr_ptr] <= push_entry_i;
        end
    end

    a_no_push_full: assert property (
        @(posedge clk_i) disable iff (rst_i) (push_i && !flush_i) |-> !full
    );

    a_no_pop_empty: assert property (
        @(posedge clk_i) disable iff (rst_i) pop_i |-> head_valid_o
    );

endmodule

`default_nettype wire

// ==== logic/ex_retire.sv ====
`default_nettype none

module ex_retire (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              wb_stall_i,
    input  logic              head_valid_i,
    input  ex_pkg::ex_entry_t head_entry_i,
    output logic              pop_o,
    output logic              flush_o,
    output logic              valid_o,
    output ex_pkg::word_t     pc_o,
    output logic              rd_we_o,
    output ex_pkg::reg_addr_t rd_a_o,
    output ex_pkg::word_t     rd_wd_o,
    output logic              branch_o,
    output logic              branch_taken_o,
    output ex_pkg::word_t     branch_target_o,
    output logic              branch_is_call_o,
    output logic              branch_is_ret_o,
    output logic              branch_is_jmp_o,
    output logic              redirect_o,
    output ex_pkg::word_t     redirect_pc_o
);
    import ex_pkg::*;

    word_t alu_result;
    logic  cond;
    logic  is_jump, is_cond, is_branch;
    logic  taken, mispredict;
    logic  rd_link, rs1_link;
    logic  is_call, is_ret, is_jmp;

    ex_alu u_alu (
        .uop_i    (head_entry_i.uop),
        .op_a_i   (head_entry_i.op_a),
        .op_b_i   (head_entry_i.op_b),
        .rs2_i    (head_entry_i.rs2),
        .pc_i     (head_entry_i.pc),
        .result_o (alu_result),
        .cond_o   (cond)
    );

    assign is_jump   = head_entry_i.uop inside {UOP_JAL, UOP_JALR};
    assign is_cond   = head_entry_i.uop inside {UOP_BEQ, UOP_BNE, UOP_BLT, UOP_BGE,
                                                UOP_BLTU, UOP_BGEU};
    assign is_branch = is_jump || is_cond;
    assign taken     = is_jump || (is_cond && cond);

    assign rd_link  = (head_entry_i.rd_a == LINK_RA) || (head_entry_i.rd_a == LINK_T0);
    assign rs1_link = (head_entry_i.rs1_a == LINK_RA) || (head_entry_i.rs1_a == LINK_T0);

    // ras push/pop hints from the link register usage
    always_comb begin
        is_call = 1'b0;
        is_ret  = 1'b0;
        is_jmp  = 1'b0;
        if (head_entry_i.uop == UOP_JAL) begin
            is_call = rd_link;
            is_jmp  = !rd_link;
        end else if (head_entry_i.uop == UOP_JALR) begin
            is_call = rd_link;
            is_ret  = rs1_link && !(rd_link && head_entry_i.rd_a == head_entry_i.rs1_a);
            is_jmp  = !rd_link && !rs1_link;
        end
    end

    assign mispredict = is_branch && (taken ? (!head_entry_i.pred_taken ||
                                               head_entry_i.pred_next_pc != head_entry_i.target)
                                            : head_entry_i.pred_taken);

    // head is younger work while a redirect is out, so no pop then
    assign pop_o   = head_valid_i && !wb_stall_i && !redirect_o;
    assign flush_o = redirect_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o    <= 1'b0;
            branch_o   <= 1'b0;
            redirect_o <= 1'b0;
        end else begin
            valid_o    <= pop_o;
            branch_o   <= pop_o && is_branch;
            redirect_o <= pop_o && mispredict;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            pc_o             <= head_entry_i.pc;
            rd_we_o          <= head_entry_i.rd_we;
            rd_a_o           <= head_entry_i.rd_a;
            // auipc writes its pc relative target
            rd_wd_o          <= (head_entry_i.uop == UOP_AUIPC) ? head_entry_i.target : alu_result;
            branch_taken_o   <= taken;
            branch_target_o  <= head_entry_i.target;
            branch_is_call_o <= is_call;
            branch_is_ret_o  <= is_ret;
            branch_is_jmp_o  <= is_jmp;
            redirect_pc_o    <= taken ? head_entry_i.target : head_entry_i.pc + INSN_BYTES;
        end
    end

    // a redirect always comes with its own retiring branch
    a_redirect_squash: assert property (
        @(posedge clk_i) disable iff (rst_i)
        redirect_o |-> (valid_o && branch_o)
    );

endmodule

`default_nettype wire

// ==== logic/ex_top.sv ====
`default_nettype none

module ex_top #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              valid_i,
    input  ex_pkg::uop_t      uop_i,
    input  ex_pkg::word_t     pc_i,
    input  ex_pkg::reg_addr_t rs1_a_i,
    input  ex_pkg::word_t     rs1_d_i,
    input  ex_pkg::word_t     rs2_d_i,
    input  ex_pkg::word_t     imm_i,
    input  ex_pkg::reg_addr_t rd_a_i,
    input  logic              rd_we_i,
    input  ex_pkg::word_t     next_pc_i,
    input  logic              next_taken_i,
    input  logic              wb_stall_i,
    output logic              valid_o,
    output ex_pkg::word_t     pc_o,
    output logic              rd_we_o,
    output ex_pkg::reg_addr_t rd_a_o,
    output ex_pkg::word_t     rd_wd_o,
    output logic              branch_o,
    output logic              branch_taken_o,
    output ex_pkg::word_t     branch_target_o,
    output logic              branch_is_call_o,
    output logic              branch_is_ret_o,
    output logic              branch_is_jmp_o,
    output logic              redirect_o,
    output ex_pkg::word_t     redirect_pc_o,
    output logic              stall_req_o
);
    import ex_pkg::*;

    logic      issue_valid;
    ex_entry_t issue_entry;
    logic      head_valid;
    ex_entry_t head_entry;
    logic      pop;
    logic      flush;

    ex_issue u_issue (
        .clk_i, .rst_i,
        .flush_i       (flush),
        .almost_full_i (stall_req_o),
        .valid_i, .uop_i, .pc_i, .rs1_a_i, .rs1_d_i, .rs2_d_i, .imm_i,
        .rd_a_i, .rd_we_i, .next_pc_i, .next_taken_i,
        .valid_o       (issue_valid),
        .entry_o       (issue_entry)
    );

    ex_queue #(
        .DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk_i, .rst_i,
        .flush_i       (flush),
        .push_i        (issue_valid),
        .push_entry_i  (issue_entry),
        .pop_i         (pop),
        .head_valid_o  (head_valid),
        .head_entry_o  (head_entry),
        .almost_full_o (stall_req_o)
    );

    ex_retire u_retire (
        .clk_i, .rst_i, .wb_stall_i,
        .head_valid_i  (head_valid),
        .head_entry_i  (head_entry),
        .pop_o         (pop),
        .flush_o       (flush),
        .valid_o, .pc_o, .rd_we_o, .rd_a_o, .rd_wd_o,
        .branch_o, .branch_taken_o, .branch_target_o,
        .branch_is_call_o, .branch_is_ret_o, .branch_is_jmp_o,
        .redirect_o, .redirect_pc_o
    );

endmodule

`default_nettype wire

// ==== include/ex_tb_model.svh ====
`ifndef EX_TB_MODEL_SVH
`define EX_TB_MODEL_SVH

// what one operation should show on the retire outputs
typedef struct packed {
    word_t     pc;
    logic      rd_we;
    reg_addr_t rd_a;
    word_t     rd_wd;
    logic      wd_valid;    // conditional branches write nothing useful
    logic      branch;
    logic      taken;
    word_t     target;
    logic      call;
    logic      ret;
    logic      jmp;
    logic      redirect;
    word_t     redirect_pc;
} exp_t;

function automatic logic is_link(input reg_addr_t r);
    return (r == 5'd1) || (r == 5'd5);  // ra or t0
endfunction

// rv32i integer result, immediate forms take imm in place of rs2
function automatic word_t int_result(input uop_t u, input word_t pc, input word_t a,
                                     input word_t b, input word_t imm);
    word_t y;
    y = (u inside {UOP_ADDI, UOP_ANDI, UOP_ORI, UOP_XORI, UOP_SLTI, UOP_SLTIU,
                   UOP_SLLI, UOP_SRLI, UOP_SRAI}) ? imm : b;
    case (u)
        UOP_ADD, UOP_ADDI:   return a + y;
        UOP_SUB:             return a - y;
        UOP_AND, UOP_ANDI:   return a & y;
        UOP_OR, UOP_ORI:     return a | y;
        UOP_XOR, UOP_XORI:   return a ^ y;
        UOP_SLT, UOP_SLTI:   return ($signed(a) < $signed(y)) ? 32'd1 : 32'd0;
        UOP_SLTU, UOP_SLTIU: return (a < y) ? 32'd1 : 32'd0;
        UOP_SLL, UOP_SLLI:   return a << y[4:0];
        UOP_SRL, UOP_SRLI:   return a >> y[4:0];
        UOP_SRA, UOP_SRAI:   return $signed(a) >>> y[4:0];
        UOP_LUI:             return imm;
        UOP_AUIPC:           return pc + imm;
        default:             return pc + 32'd4;     // jal and jalr link value
    endcase
endfunction

function automatic logic cond_taken(input uop_t u, input word_t a, input word_t b);
    case (u)
        UOP_BEQ:  return a == b;
        UOP_BNE:  return a != b;
        UOP_BLT:  return $signed(a) < $signed(b);
        UOP_BGE:  return $signed(a) >= $signed(b);
        UOP_BLTU: return a < b;
        UOP_BGEU: return a >= b;
        default:  return 1'b1;  // unconditional jumps
    endcase
endfunction

function automatic exp_t make_expected(input uop_t u, input word_t pc, input word_t a,
                                       input word_t b, input word_t imm,
                                       input reg_addr_t rd, input reg_addr_t rs1,
                                       input logic we, input logic p_taken,
                                       input word_t p_pc);
    exp_t e;
    logic jump;
    jump          = (u == UOP_JAL) || (u == UOP_JALR);
    e.pc          = pc;
    e.rd_we       = we;
    e.rd_a        = rd;
    e.rd_wd       = int_result(u, pc, a, b, imm);
    e.branch      = jump || (u inside {UOP_BEQ, UOP_BNE, UOP_BLT, UOP_BGE, UOP_BLTU, UOP_BGEU});
    e.wd_valid    = !e.branch || jump;
    e.taken       = e.branch && cond_taken(u, a, b);
    e.target      = (u == UOP_JALR) ? a + imm : pc + imm;
    // return address stack table of the rv32i spec
    e.call        = jump && is_link(rd);
    e.ret         = (u == UOP_JALR) && is_link(rs1) && !(is_link(rd) && rd == rs1);
    e.jmp         = jump && !e.call && !e.ret;
    e.redirect    = e.branch && (e.taken ? (!p_taken || p_pc != e.target) : p_taken);
    e.redirect_pc = e.taken ? e.target : pc + 32'd4;
    return e;
endfunction

`endif

// ==== test/ex_tb.sv ====
`default_nettype none

module ex_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import ex_pkg::*;

    localparam int QUEUE_DEPTH = 4;
    localparam int N_OPS       = 300;
    localparam int DRAIN_LIMIT = 200;  // cycles
    localparam int STALL_LIMIT = 50;

    logic      clk_i, rst_i, valid_i, rd_we_i, next_taken_i, wb_stall_i;
    uop_t      uop_i;
    word_t     pc_i, rs1_d_i, rs2_d_i, imm_i, next_pc_i;
    reg_addr_t rs1_a_i, rd_a_i;
    logic      valid_o, rd_we_o, branch_o, branch_taken_o, redirect_o, stall_req_o;
    logic      branch_is_call_o, branch_is_ret_o, branch_is_jmp_o;
    reg_addr_t rd_a_o;
    word_t     pc_o, rd_wd_o, branch_target_o, redirect_pc_o;

    `include "ex_tb_model.svh"

    exp_t exp_q[$];         // sent and not yet retired, oldest first
    int   checks     = 0;
    int   errors     = 0;
    int   in_flight  = 0;
    int   sent       = 0;
    logic stall_last = 1'b0;  // wb_stall_i as sampled at the previous edge

    ex_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        checks++;
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            errors++;
        end
    endtask

    function automatic reg_addr_t pick_reg();
        case ($urandom_range(3))
            0:       return 5'd1;
            1:       return 5'd5;
            default: return reg_addr_t'($urandom);
        endcase
    endfunction

    // mode 0 alu, 1 jumps, 2 branches, 3 everything with bad predictions
    task automatic drive_op(input int mode);
        uop_t      u;
        word_t     pc, a, b, imm, p_pc;
        reg_addr_t rd, rs1;
        logic      we, p_taken;
        exp_t      e;
        case (mode)
            0:       u = uop_t'($urandom_range(int'(UOP_AUIPC)));
            1:       u = $urandom_range(1) ? UOP_JALR : UOP_JAL;
            2:       u = uop_t'($urandom_range(int'(UOP_BGEU), int'(UOP_BEQ)));
            default: u = uop_t'($urandom_range(int'(UOP_BGEU)));
        endcase
        pc  = $urandom & 32'hffff_fffc;
        a   = $urandom;
        b   = ($urandom_range(3) == 0) ? a : $urandom;   // equal operands now and then
        imm = $urandom;
        rd  = pick_reg();
        rs1 = pick_reg();
        we  = $urandom_range(1);
        e   = make_expected(u, pc, a, b, imm, rd, rs1, we, 1'b0, 32'd0);
        p_taken = e.taken;
        p_pc    = e.redirect_pc;
        if (mode == 3 && $urandom_range(1) == 1) begin
            p_taken = $urandom_range(1);
            p_pc    = $urandom_range(1) ? e.target : e.target + 32'd4;
        end
        e = make_expected(u, pc, a, b, imm, rd, rs1, we, p_taken, p_pc);
        valid_i      <= 1'b1;
        uop_i        <= u;
        pc_i         <= pc;
        rs1_a_i      <= rs1;
        rs1_d_i      <= a;
        rs2_d_i      <= b;
        imm_i        <= imm;
        rd_a_i       <= rd;
        rd_we_i      <= we;
        next_pc_i    <= p_pc;
        next_taken_i <= p_taken;
        exp_q.push_back(e);
        in_flight++;
        sent++;
    endtask

    // outputs read right at the edge still hold their pre-edge values
    task automatic observe();
        exp_t e;
        if (stall_last) begin
            check_value("valid_o", valid_o, 1'b0);
        end
        if (valid_o && exp_q.size() == 0) begin
            $display("at %0t ns a result retired with no operation pending", $time);
            errors++;
        end else if (valid_o) begin
            e = exp_q.pop_front();
            in_flight--;
            check_value("pc_o", pc_o, e.pc);  // also keeps issue order
            check_value("rd_we_o", rd_we_o, e.rd_we);
            check_value("rd_a_o", rd_a_o, e.rd_a);
            if (e.wd_valid) begin
                check_value("rd_wd_o", rd_wd_o, e.rd_wd);
            end
            check_value("branch_o", branch_o, e.branch);
            check_value("redirect_o", redirect_o, e.redirect);
            if (e.branch) begin
                check_value("branch_taken_o", branch_taken_o, e.taken);
                check_value("branch_target_o", branch_target_o, e.target);
                check_value("branch_is_call_o", branch_is_call_o, e.call);
                check_value("branch_is_ret_o", branch_is_ret_o, e.ret);
                check_value("branch_is_jmp_o", branch_is_jmp_o, e.jmp);
            end
            if (e.redirect) begin
                check_value("redirect_pc_o", redirect_pc_o, e.redirect_pc);
            end
        end else begin
            check_value("redirect_o", redirect_o, 1'b0);
        end
        if (redirect_o) begin
            exp_q.delete();     // all younger work, and this cycle's valid_i, is squashed
            in_flight = 0;
        end
        stall_last = wb_stall_i;
    endtask

    task automatic cycle(input int mode, input logic send, input logic stall);
        @(posedge clk_i);
        observe();
        wb_stall_i <= stall;
        if (send && !stall_req_o && in_flight < QUEUE_DEPTH - 1) begin
            drive_op(mode);
        end else begin
            valid_i <= 1'b0;
        end
    endtask

    task automatic drain(input int mode);
        int t;
        t = 0;
        while (exp_q.size() != 0 && t < DRAIN_LIMIT) begin
            cycle(mode, 1'b0, 1'b0);
            t++;
        end
        if (exp_q.size() != 0) begin
            $display("timed out with %0d results never retired", exp_q.size());
            errors++;
        end
        repeat (3) cycle(mode, 1'b0, 1'b0);   // nothing stray may follow
    endtask

    task automatic run_test(input string name, input int mode, input int n);
        int e0, s0, burst;
        e0    = errors;
        s0    = sent;
        burst = 0;
        repeat (n) begin
            if (burst == 0 && $urandom_range(15) == 0) begin
                burst = $urandom_range(6, 2);   // write-back stall burst
            end
            cycle(mode, 1'b1, burst > 0);
            if (burst > 0) begin
                burst--;
            end
        end
        drain(mode);
        $display("%-12s %0d ops, %0d errors", name, sent - s0, errors - e0);
    endtask

    task automatic stall_test();
        int e0, s0, t;
        e0 = errors;
        s0 = sent;
        t  = 0;
        while (!stall_req_o && t < STALL_LIMIT) begin
            cycle(0, 1'b1, 1'b1);
            t++;
        end
        if (!stall_req_o) begin
            $display("stall_req_o never rose while write-back was stalled");
            errors++;
        end
        repeat (5) cycle(0, 1'b1, 1'b1);
        drain(0);
        $display("%-12s %0d ops, %0d errors", "wb_stall", sent - s0, errors - e0);
    endtask

    task automatic reset_test();
        int e0;
        e0 = errors;
        repeat (8) @(posedge clk_i);
        rst_i <= 1'b0;
        @(posedge clk_i);
        check_value("valid_o", valid_o, 1'b0);
        check_value("redirect_o", redirect_o, 1'b0);
        check_value("branch_o", branch_o, 1'b0);
        check_value("stall_req_o", stall_req_o, 1'b0);
        cycle(0, 1'b1, 1'b0);   // first operation after reset
        drain(0);
        $display("%-12s 1 op, %0d errors", "reset", errors - e0);
    endtask

    initial begin
        void'($urandom(32'hffd3));
        rst_i        = 1'b1;
        valid_i      = 1'b0;
        uop_i        = UOP_ADD;
        pc_i         = '0;
        rs1_a_i      = '0;
        rs1_d_i      = '0;
        rs2_d_i      = '0;
        imm_i        = '0;
        rd_a_i       = '0;
        rd_we_i      = 1'b0;
        next_pc_i    = '0;
        next_taken_i = 1'b0;
        wb_stall_i   = 1'b0;
        reset_test();
        run_test("alu", 0, N_OPS);
        run_test("jump", 1, N_OPS);
        run_test("branch", 2, N_OPS);
        run_test("mispredict", 3, N_OPS);
        stall_test();
        $display("%0d ops sent, %0d checks, %0d errors", sent, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== ex_top.f ====
+incdir+include
logic/ex_pkg.sv
logic/ex_alu.sv
logic/ex_issue.sv
logic/ex_queue.sv
logic/ex_retire.sv
logic/ex_top.sv
test/ex_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the execute stage testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module ex_tb -f ex_top.f -Mdir "$BUILD_DIR" -o ex_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/ex_tb_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q '\*\*\* TEST FAILED \*\*\*' "$LOG"; then
    exit 1
fi
exit 0
